// ==== all.f ====
verilog/storebuffer_pkg.sv
verilog/storebuffer_if.sv
verilog/storebuffer_array.sv
verilog/storebuffer_lookup.sv
verilog/storebuffer_backing.sv
verilog/storebuffer.sv
verification/backing_memory_model.sv
verification/storebuffer_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing -Wno-fatal --top-module storebuffer_tb \
  -Mdir build/obj -o storebuffer_sim -f all.f

./build/obj/storebuffer_sim | tee build/sim.log

if grep -q "Simulation PASSED" build/sim.log; then
  exit 0
else
  echo "run.sh: testbench reported failure, see build/sim.log"
  exit 1
fi

// ==== verification/backing_memory_model.sv ====
module backing_memory_model (
  input logic clock,
  input logic reset,
  input logic [2:0] mem_delay,
  input logic mem_valid,
  input logic mem_store,
  input logic [31:0] mem_addr,
  input logic [63:0] mem_wdata,
  output logic mem_ready,
  output logic [63:0] mem_rdata
);

  // 64 doublewords, filled by the testbench at time zero
  logic [7:0] storage [0:511];
  logic [2:0] wait_count;

  // Answers each request after mem_delay idle cycles
  always @(posedge clock) begin
    if (!reset) begin
      mem_ready <= 1'b0;
      mem_rdata <= '0;
      wait_count <= '0;
    end else begin
      mem_ready <= 1'b0;
      if (mem_valid && !mem_ready) begin
        if (wait_count == mem_delay) begin
          mem_ready <= 1'b1;
          wait_count <= '0;
          for (int i = 0; i < 8; i++) begin
            if (mem_store) begin
              storage[{mem_addr[8:3], 3'(i)}] <= mem_wdata[8*i +: 8];
            end else begin
              mem_rdata[8*i +: 8] <= storage[{mem_addr[8:3], 3'(i)}];
            end
          end
        end else begin
          wait_count <= wait_count + 3'd1;
        end
      end
    end
  end

endmodule

// ==== verification/storebuffer_tb.sv ====
module storebuffer_tb;

  localparam int reset_cycles = 16;
  localparam int random_ops = 300;
  localparam int total_ops = random_ops + 20;
  localparam int cycles_per_op = 40;

  logic clock = 1'b0;
  logic reset;
  logic req_valid;
  logic req_fence;
  logic [31:0] req_addr;
  logic [63:0] req_wdata;
  logic [7:0] req_strb;
  logic resp_ready;
  logic [63:0] resp_rdata;
  logic mem_valid;
  logic mem_store;
  logic [31:0] mem_addr;
  logic [63:0] mem_wdata;
  logic mem_ready;
  logic [63:0] mem_rdata;
  logic [2:0] mem_delay;

  logic [31:0] rng_state = 32'h2ca7;
  logic [7:0] shadow [0:511];
  int read_count = 0;
  int test_errors;
  int pass_count;
  int fail_count;
  int cycles;
  logic [63:0] rdata;

  storebuffer storebuffer_inst (.*);

  backing_memory_model memory (.*);

  always #50 clock = ~clock;

  // Refill reads seen on the memory side
  always @(negedge clock) begin
    if (mem_valid && mem_ready && !mem_store) begin
      read_count++;
    end
  end

  // ******************************
  // Helpers
  // ******************************

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [7:0] fill_byte(input int addr);
    return 8'(addr ^ (addr >> 5)) + 8'h31;
  endfunction

  // Byte i of the doubleword sits at base + i
  function automatic logic [63:0] shadow_dword(input logic [31:0] addr);
    logic [63:0] value;
    for (int i = 0; i < 8; i++) begin
      value[8*i +: 8] = shadow[{addr[8:3], 3'(i)}];
    end
    return value;
  endfunction

  function automatic logic [63:0] memory_dword(input logic [31:0] addr);
    logic [63:0] value;
    for (int i = 0; i < 8; i++) begin
      value[8*i +: 8] = memory.storage[{addr[8:3], 3'(i)}];
    end
    return value;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("** Error %s: expected %h, actual %h", name, expected, actual);
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("%s: passed", name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Sends one request and leaves the response in rdata and its latency in cycles
  task automatic send_request(input logic fence, input logic [31:0] addr,
                              input logic [63:0] wdata, input logic [7:0] strb);
    logic [31:0] r;
    r = next_random();
    @(posedge clock);
    req_valid <= 1'b1;
    req_fence <= fence;
    req_addr <= addr;
    req_wdata <= wdata;
    req_strb <= strb;
    mem_delay <= r[2:0];
    @(posedge clock);
    req_valid <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (resp_ready !== 1'b1);
    rdata = resp_rdata;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        shadow[{addr[8:3], 3'(i)}] = wdata[8*i +: 8];
      end
    end
  endtask

  // ******************************
  // Tests
  // ******************************

  initial begin
    logic [31:0] addr;
    logic [31:0] r;
    logic [63:0] wdata;
    logic [7:0] strb;
    int reads_before;
    reset = 1'b0;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    req_strb = '0;
    mem_delay = '0;
    test_errors = 0;
    pass_count = 0;
    fail_count = 0;
    for (int i = 0; i < 512; i++) begin
      shadow[i] = fill_byte(i);
      memory.storage[i] <= fill_byte(i);
    end

    for (int i = 0; i < reset_cycles + 4; i++) begin
      @(posedge clock);
      if (i == reset_cycles - 1) begin
        reset <= 1'b1;
      end
      @(negedge clock);
      if (resp_ready !== 1'b0 || mem_valid !== 1'b0) begin
        $display("** Error reset: resp_ready or mem_valid not low in cycle %0d", i);
        test_errors++;
      end
    end
    reads_before = read_count;
    send_request(1'b0, 32'h40, 64'd0, 8'h00);
    if (read_count == reads_before) begin
      $display("** Error reset: first load was not refilled from memory");
      test_errors++;
    end
    if (rdata !== shadow_dword(32'h40)) report_mismatch("reset", shadow_dword(32'h40), rdata);
    finish_test("reset");

    send_request(1'b0, 32'h88, 64'h0123_4567_89ab_cdef, 8'ha5);
    if (rdata !== 64'd0) report_mismatch("store_load", 64'd0, rdata);
    send_request(1'b0, 32'h88, 64'd0, 8'h00);
    if (cycles != 1) begin
      $display("** Error store_load: resident load took %0d cycles instead of 1", cycles);
      test_errors++;
    end
    if (rdata !== shadow_dword(32'h88)) report_mismatch("store_load", shadow_dword(32'h88), rdata);
    finish_test("store_load");

    // Index 2 with two different tags
    send_request(1'b0, 32'h10, 64'hfeed_face_cafe_beef, 8'hff);
    send_request(1'b0, 32'h90, 64'd0, 8'h00);
    if (memory_dword(32'h10) !== shadow_dword(32'h10)) begin
      report_mismatch("eviction", shadow_dword(32'h10), memory_dword(32'h10));
    end
    if (rdata !== shadow_dword(32'h90)) report_mismatch("eviction", shadow_dword(32'h90), rdata);
    send_request(1'b0, 32'h10, 64'd0, 8'h00);
    if (rdata !== shadow_dword(32'h10)) report_mismatch("eviction", shadow_dword(32'h10), rdata);
    finish_test("eviction");

    for (int n = 0; n < random_ops; n++) begin
      r = next_random();
      addr = {23'd0, r[5:0], 3'd0};
      strb = r[6] ? r[15:8] : 8'h00;
      wdata = {next_random(), next_random()};
      send_request(1'b0, addr, wdata, strb);
      if (strb == 8'h00 && rdata !== shadow_dword(addr)) begin
        report_mismatch("random_mix", shadow_dword(addr), rdata);
      end
      if (strb != 8'h00 && rdata !== 64'd0) report_mismatch("random_mix", 64'd0, rdata);
    end
    finish_test("random_mix");

    // Make 0x88 resident so that the load after the fence has to miss
    send_request(1'b0, 32'h88, 64'd0, 8'h00);
    if (rdata !== shadow_dword(32'h88)) report_mismatch("fence", shadow_dword(32'h88), rdata);
    send_request(1'b1, 32'd0, 64'd0, 8'h00);
    if (rdata !== 64'd0) report_mismatch("fence", 64'd0, rdata);
    for (int a = 0; a < 512; a += 8) begin
      if (memory_dword(a) !== shadow_dword(a)) begin
        report_mismatch("fence", shadow_dword(a), memory_dword(a));
      end
    end
    reads_before = read_count;
    send_request(1'b0, 32'h88, 64'd0, 8'h00);
    if (read_count == reads_before) begin
      $display("** Error fence: load after the fence did not read memory");
      test_errors++;
    end
    if (rdata !== shadow_dword(32'h88)) report_mismatch("fence", shadow_dword(32'h88), rdata);
    finish_test("fence");

    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (reset_cycles + total_ops * cycles_per_op) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d cycles",
             reset_cycles + total_ops * cycles_per_op);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== verilog/storebuffer.sv ====
module storebuffer (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input logic [31:0] req_addr,
  input logic [63:0] req_wdata,
  input logic [7:0] req_strb,
  output logic resp_ready,
  output logic [63:0] resp_rdata,
  output logic mem_valid,
  output logic mem_store,
  output logic [31:0] mem_addr,
  output logic [63:0] mem_wdata,
  input logic mem_ready,
  input logic [63:0] mem_rdata
);

  array_port_if array_port ();
  backing_req_if backing_req ();

  storebuffer_array array_inst (
    .clock(clock),
    .port(array_port)
  );

  storebuffer_lookup lookup_inst (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_fence(req_fence),
    .req_addr(req_addr),
    .req_wdata(req_wdata),
    .req_strb(req_strb),
    .resp_ready(resp_ready),
    .resp_rdata(resp_rdata),
    .array(array_port),
    .backing(backing_req)
  );

  storebuffer_backing backing_inst (
    .clock(clock),
    .reset(reset),
    .req(backing_req),
    .mem_valid(mem_valid),
    .mem_store(mem_store),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata)
  );

endmodule

// ==== verilog/storebuffer_array.sv ====
module storebuffer_array (
  input logic clock,
  array_port_if.array port
);

  // All entries start out invalid
  storebuffer_pkg::entry_type entries [0:storebuffer_pkg::storebuffer_depth-1] =
    '{default: storebuffer_pkg::init_entry};

  always_ff @(posedge clock) begin
    if (port.wen) begin
      entries[port.waddr] <= port.wdata;
    end
  end

  // Asynchronous read, the lookup compares in the same cycle
  always_comb begin
    port.rdata = entries[port.raddr];
  end

endmodule

// ==== verilog/storebuffer_backing.sv ====
module storebuffer_backing (
  input logic clock,
  input logic reset,
  backing_req_if.backing req,
  output logic mem_valid,
  output logic mem_store,
  output logic [31:0] mem_addr,
  output logic [63:0] mem_wdata,
  input logic mem_ready,
  input logic [63:0] mem_rdata
);

  logic evict_q;
  logic fetch_q;
  logic mem_valid_q;
  logic mem_store_q;
  logic done_q;

  logic [31:0] fetch_addr_q;
  logic [31:0] victim_addr_q;
  logic [63:0] victim_data_q;
  logic [63:0] fill_data_q;

  logic handshake;

  assign handshake = mem_valid_q & mem_ready;

  // ******************************
  // Write-back then refill
  // ******************************

  always_ff @(posedge clock) begin
    if (!reset) begin
      evict_q <= 1'b0;
      fetch_q <= 1'b0;
      mem_valid_q <= 1'b0;
      mem_store_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (req.start) begin
        evict_q <= req.evict;
        fetch_q <= req.fetch;
        mem_valid_q <= 1'b1;
        mem_store_q <= req.evict;
      end else if (handshake) begin
        mem_valid_q <= 1'b0;
        if (mem_store_q) begin
          evict_q <= 1'b0;
          done_q <= !fetch_q;
        end else begin
          fetch_q <= 1'b0;
          done_q <= 1'b1;
        end
      end else if (!mem_valid_q && fetch_q && !evict_q) begin
        // Victim is out, issue the read
        mem_valid_q <= 1'b1;
        mem_store_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req.start) begin
      fetch_addr_q <= req.fetch_addr;
      victim_addr_q <= req.victim_addr;
      victim_data_q <= req.victim_data;
    end
    if (handshake && !mem_store_q) begin
      fill_data_q <= mem_rdata;
    end
  end

  assign mem_valid = mem_valid_q;
  assign mem_store = mem_store_q;
  assign mem_addr = mem_store_q ? victim_addr_q : fetch_addr_q;
  assign mem_wdata = mem_store_q ? victim_data_q : 64'd0;

  assign req.done = done_q;
  assign req.fill_data = fill_data_q;

endmodule

// ==== verilog/storebuffer_if.sv ====
// Lookup stage to entry array
interface array_port_if;

  logic [storebuffer_pkg::index_width-1:0] raddr;
  storebuffer_pkg::entry_type rdata;
  logic wen;
  logic [storebuffer_pkg::index_width-1:0] waddr;
  storebuffer_pkg::entry_type wdata;

  modport lookup(output raddr, output wen, output waddr, output wdata, input rdata);

  modport array(input raddr, input wen, input waddr, input wdata, output rdata);

endinterface

// Lookup stage to memory stage, one transaction at a time
interface backing_req_if;

  logic start;
  logic fetch;
  logic evict;
  logic [31:0] fetch_addr;
  logic [31:0] victim_addr;
  logic [63:0] victim_data;
  logic done;
  logic [63:0] fill_data;

  modport lookup(
    output start, output fetch, output evict,
    output fetch_addr, output victim_addr, output victim_data,
    input done, input fill_data
  );

  modport backing(
    input start, input fetch, input evict,
    input fetch_addr, input victim_addr, input victim_data,
    output done, output fill_data
  );

endinterface

// ==== verilog/storebuffer_lookup.sv ====
module storebuffer_lookup (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input logic [31:0] req_addr,
  input logic [63:0] req_wdata,
  input logic [7:0] req_strb,
  output logic resp_ready,
  output logic [63:0] resp_rdata,
  array_port_if.lookup array,
  backing_req_if.lookup backing
);

  typedef enum logic [1:0] {
    idle,
    wait_mem,
    fence_walk
  } state_type;

  state_type state_q;
  logic [storebuffer_pkg::index_width-1:0] walk_q;
  logic pending_q;
  logic start_q;
  logic fetch_q;
  logic evict_q;
  logic resp_ready_q;
  logic [63:0] resp_rdata_q;

  // Latched request and victim
  logic [31:0] addr_q;
  logic [63:0] wdata_q;
  logic [7:0] strb_q;
  logic [31:0] victim_addr_q;
  logic [63:0] victim_data_q;

  logic [storebuffer_pkg::index_width-1:0] req_index;
  logic [storebuffer_pkg::tag_width-1:0] req_tag;
  logic is_store;
  logic hit;
  logic victim_dirty;
  logic walk_step;
  storebuffer_pkg::entry_type merged_entry;
  storebuffer_pkg::entry_type fill_entry;

  function automatic logic [63:0] merge_bytes(
    input logic [63:0] old_data,
    input logic [63:0] new_data,
    input logic [7:0] strb
  );
    logic [63:0] result;
    result = old_data;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return result;
  endfunction

  // ******************************
  // Compare and merge
  // ******************************

  always_comb begin
    req_index = req_addr[storebuffer_pkg::offset_width +: storebuffer_pkg::index_width];
    req_tag = req_addr[storebuffer_pkg::offset_width +: storebuffer_pkg::tag_width];
    is_store = |req_strb;

    array.raddr = (state_q == fence_walk) ? walk_q : req_index;
    hit = array.rdata.valid && (array.rdata.tag == req_tag);
    victim_dirty = array.rdata.valid & array.rdata.dirty;
    // During the walk, move on once the entry is clean or its write-back is done
    walk_step = pending_q ? backing.done : !victim_dirty;

    merged_entry = array.rdata;
    merged_entry.dirty = array.rdata.dirty | is_store;
    merged_entry.data = merge_bytes(array.rdata.data, req_wdata, req_strb);

    fill_entry.valid = 1'b1;
    fill_entry.dirty = |strb_q;
    fill_entry.tag = addr_q[storebuffer_pkg::offset_width +: storebuffer_pkg::tag_width];
    fill_entry.data = merge_bytes(backing.fill_data, wdata_q, strb_q);

    array.wen = 1'b0;
    array.waddr = req_index;
    array.wdata = merged_entry;
    case (state_q)
      idle: begin
        array.wen = req_valid & !req_fence & hit & is_store;
      end
      wait_mem: begin
        array.wen = backing.done;
        array.waddr = addr_q[storebuffer_pkg::offset_width +: storebuffer_pkg::index_width];
        array.wdata = fill_entry;
      end
      default: begin
        // Fence clears each entry as it is visited
        array.wen = !pending_q;
        array.waddr = walk_q;
        array.wdata = storebuffer_pkg::init_entry;
      end
    endcase
  end

  // ******************************
  // Control
  // ******************************

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= idle;
      walk_q <= '0;
      pending_q <= 1'b0;
      start_q <= 1'b0;
      fetch_q <= 1'b0;
      evict_q <= 1'b0;
      resp_ready_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      resp_ready_q <= 1'b0;
      case (state_q)
        idle: begin
          if (req_valid) begin
            if (req_fence) begin
              state_q <= fence_walk;
              walk_q <= '0;
            end else if (hit) begin
              resp_ready_q <= 1'b1;
            end else begin
              start_q <= 1'b1;
              fetch_q <= 1'b1;
              evict_q <= victim_dirty;
              state_q <= wait_mem;
            end
          end
        end
        wait_mem: begin
          if (backing.done) begin
            resp_ready_q <= 1'b1;
            state_q <= idle;
          end
        end
        default: begin
          if (walk_step) begin
            pending_q <= 1'b0;
            if (&walk_q) begin
              resp_ready_q <= 1'b1;
              state_q <= idle;
            end else begin
              walk_q <= walk_q + 1'b1;
            end
          end else if (!pending_q) begin
            // Write-back only, nothing to refill
            start_q <= 1'b1;
            fetch_q <= 1'b0;
            evict_q <= 1'b1;
            pending_q <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == idle && req_valid) begin
      addr_q <= req_addr;
      wdata_q <= req_wdata;
      strb_q <= req_strb;
      resp_rdata_q <= (is_store || req_fence) ? 64'd0 : array.rdata.data;
    end
    if (state_q == wait_mem && backing.done) begin
      resp_rdata_q <= (|strb_q) ? 64'd0 : backing.fill_data;
    end
    if (state_q == fence_walk) begin
      resp_rdata_q <= 64'd0;
    end
    if ((state_q == idle && req_valid) || (state_q == fence_walk && !pending_q)) begin
      victim_addr_q <= {array.rdata.tag, {storebuffer_pkg::offset_width{1'b0}}};
      victim_data_q <= array.rdata.data;
    end
  end

  assign backing.start = start_q;
  assign backing.fetch = fetch_q;
  assign backing.evict = evict_q;
  assign backing.fetch_addr = {addr_q[31:storebuffer_pkg::offset_width],
                               {storebuffer_pkg::offset_width{1'b0}}};
  assign backing.victim_addr = victim_addr_q;
  assign backing.victim_data = victim_data_q;

  assign resp_ready = resp_ready_q;
  assign resp_rdata = resp_rdata_q;

endmodule

// ==== verilog/storebuffer_pkg.sv ====
package storebuffer_pkg;

  // ******************************
  // Geometry
  // ******************************

  localparam int storebuffer_depth = 16;
  localparam int index_width = 4;
  localparam int tag_width = 29;

  // Byte offset inside a doubleword
  localparam int offset_width = 3;

  // ******************************
  // Entry layout
  // ******************************

  // 95 bits, valid on top, data at the bottom
  typedef struct packed {
    logic valid;
    logic dirty;
    logic [tag_width-1:0] tag;
    logic [63:0] data;
  } entry_type;

  localparam entry_type init_entry = '0;

endpackage
